/* rtl/midi_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// MIDI wire-protocol types, decoded status nibbles
// default bit period for the 25 MHz system clock
////////////////////////////////////////////////////////////////////////////

package midi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// byte level types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] midi_byte_t;	// one serial frame payload
	typedef logic [6:0] data7_t;		// data byte, msb is always 0 on the wire
	typedef logic [3:0] channel_t;		// 0..15, front panels show 1..16

	////////////////////////////////////////////////////////////////////////////
	// channel voice commands, upper nibble of the status byte
	////////////////////////////////////////////////////////////////////////////

	localparam logic [3:0] STATUS_NOTE_OFF   = 4'h8;	// key, release velocity
	localparam logic [3:0] STATUS_NOTE_ON    = 4'h9;	// key, velocity (0 = off)
	localparam logic [3:0] STATUS_PITCH_BEND = 4'hE;	// lsb, msb

	// 0xF0..0xF7 sysex and system common, 0xF8..0xFF realtime

	////////////////////////////////////////////////////////////////////////////
	// serial timing
	////////////////////////////////////////////////////////////////////////////

	// 25e6 / 31250 baud
	localparam int BAUD_CLKS_DEFAULT = 800;

endpackage

/* rtl/synth_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// voice side types for the synth control path
// pitch bend center value, default voice count
////////////////////////////////////////////////////////////////////////////

package synth_pkg;

	// per key values as handed to the voice table
	typedef logic [6:0] key_t;		// note number, 60 = middle c
	typedef logic [6:0] velocity_t;	// 1..127, 0 only ever means release

	// pitch wheel, 14 bits assembled from two data bytes
	typedef logic [13:0] pitch_t;

	////////////////////////////////////////////////////////////////////////////
	// defaults
	////////////////////////////////////////////////////////////////////////////

	// wheel at rest
	localparam pitch_t PITCH_CENTER = 14'h2000;

	// slots in the voice table when the top level does not say otherwise
	localparam int VOICES_DEFAULT = 8;

endpackage

/* rtl/midi_bit_timer.sv */
////////////////////////////////////////////////////////////////////////////
// bit period down-counter, gives the mid-bit sample strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module midi_bit_timer
	import midi_pkg::*;
#(
	parameter int CLKS_PER_BIT = BAUD_CLKS_DEFAULT
) (
	input  logic CLOCK_25,
	input  logic reset1,
	input  logic sample_start,	// start edge seen, realign
	output logic bit_tick		// mid-bit strobe
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] cnt;
	logic running;		// set by the first start edge
	logic first_half;	// between sample_start and the first tick

	assign bit_tick = running && (cnt == '0);

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			cnt        <= '0;
			running    <= 1'b0;
			first_half <= 1'b0;
		end else if (sample_start) begin
			cnt        <= HALF_LOAD;	// land in the middle of the start bit
			running    <= 1'b1;
			first_half <= 1'b1;
		end else if (bit_tick) begin
			cnt        <= FULL_LOAD;
			first_half <= 1'b0;
		end else if (running) begin
			cnt <= cnt - 1'b1;
		end
	end

	// receiver must not realign before it has even sampled the start bit
	a_no_restart_in_half: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		first_half |-> !sample_start);

endmodule

/* rtl/midi_rx.sv */
////////////////////////////////////////////////////////////////////////////
// MIDI serial receiver, 8N1 lsb first
// input sync, start detect, shift register and stop-bit check
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module midi_rx
	import midi_pkg::*;
(
	input  logic       CLOCK_25,
	input  logic       reset1,
	input  logic       midi_rxd,		// from the opto, idle high
	input  logic       bit_tick,		// mid-bit strobe from the timer
	output logic       sample_start,	// restart the timer
	output logic       byte_valid,		// one cycle, rx_byte good
	output midi_byte_t rx_byte
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;

	logic rxd_meta;		// first sync stage
	logic rxd_sync;
	logic rxd_prev;		// for the falling edge
	logic [2:0] bit_cnt;
	midi_byte_t shreg;

	////////////////////////////////////////////////////////////////////////////
	// synchronizer and start edge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			rxd_meta <= 1'b1;	// line idles high
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= midi_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign sample_start = (state == RX_IDLE) && rxd_prev && !rxd_sync;

	////////////////////////////////////////////////////////////////////////////
	// frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			state      <= RX_IDLE;
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: if (sample_start) state <= RX_START;
				RX_START: if (bit_tick) begin
					bit_cnt <= '0;
					state   <= rxd_sync ? RX_IDLE : RX_DATA;	// glitch, drop it
				end
				RX_DATA: if (bit_tick) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) state <= RX_STOP;
				end
				RX_STOP: if (bit_tick) begin
					byte_valid <= rxd_sync;	// framing error gives no pulse
					state      <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data shifts in from the top, lsb first on the wire
	always_ff @(posedge CLOCK_25) begin
		if (state == RX_DATA && bit_tick) shreg <= {rxd_sync, shreg[7:1]};
	end

	assign rx_byte = shreg;	// stable until the next frame's first data bit

	// ten bit periods per frame, a pulse can never stretch
	a_valid_single: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		byte_valid |=> !byte_valid);

endmodule

/* rtl/midi_parser.sv */
////////////////////////////////////////////////////////////////////////////
// MIDI message parser, running status and channel filter
// note on / note off events, pitch bend register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module midi_parser
	import midi_pkg::*;
	import synth_pkg::*;
(
	input  logic       CLOCK_25,
	input  logic       reset1,
	input  channel_t   midi_ch,			// channel we listen on
	input  logic       byte_valid,
	input  midi_byte_t rx_byte,
	output logic       note_on_evt,		// one cycle pulses
	output logic       note_off_evt,
	output key_t       event_key,
	output velocity_t  event_vel,
	output pitch_t     pitch_val
);

	typedef enum logic [1:0] {
		P_NO_STATUS,	// nothing to run on, data bytes dropped
		P_WAIT_D1,
		P_WAIT_D2
	} parse_state_t;

	parse_state_t state;

	logic [3:0] cur_cmd;	// running status, command nibble
	channel_t   cur_ch;		// and its channel
	data7_t     data1;		// first data byte of a two byte message

	logic is_realtime;
	logic is_system;
	logic is_status;
	logic one_data;
	logic ch_match;
	logic data_byte;
	logic msg_done;
	logic vel_zero;

	////////////////////////////////////////////////////////////////////////////
	// byte classification
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		is_realtime = (rx_byte[7:3] == 5'b11111);	// f8..ff, pass straight over
		is_system   = (rx_byte[7:4] == 4'hF);		// sysex / common, kills status
		is_status   = rx_byte[7];
		one_data    = (cur_cmd[3:1] == 3'b110);		// program change, chan pressure
		ch_match    = (cur_ch == midi_ch);
		data_byte   = byte_valid && !rx_byte[7];
		vel_zero    = (rx_byte[6:0] == 7'd0);

		// last data byte of the current message
		msg_done = data_byte && ((state == P_WAIT_D2) || (state == P_WAIT_D1 && one_data));
	end

	////////////////////////////////////////////////////////////////////////////
	// running status FSM and events
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			state        <= P_NO_STATUS;
			cur_cmd      <= '0;
			cur_ch       <= '0;
			note_on_evt  <= 1'b0;
			note_off_evt <= 1'b0;
			pitch_val    <= PITCH_CENTER;
		end else begin
			note_on_evt  <= 1'b0;
			note_off_evt <= 1'b0;

			if (byte_valid && !is_realtime) begin
				if (is_system) begin
					state <= P_NO_STATUS;
				end else if (is_status) begin
					cur_cmd <= rx_byte[7:4];	// other channels tracked too
					cur_ch  <= rx_byte[3:0];
					state   <= P_WAIT_D1;
				end else if (state == P_WAIT_D1 && !one_data) begin
					state <= P_WAIT_D2;
				end else if (state == P_WAIT_D2) begin
					state <= P_WAIT_D1;	// next data byte reuses the status
				end
			end

			if (msg_done && ch_match) begin
				if (cur_cmd == STATUS_NOTE_ON && !vel_zero) note_on_evt <= 1'b1;
				if (cur_cmd == STATUS_NOTE_OFF || (cur_cmd == STATUS_NOTE_ON && vel_zero))
					note_off_evt <= 1'b1;	// velocity 0 note on is a release
				if (cur_cmd == STATUS_PITCH_BEND)
					pitch_val <= (pitch_t'(rx_byte[6:0]) << 7) + pitch_t'(data1);
			end
		end
	end

	// payload registers
	always_ff @(posedge CLOCK_25) begin
		if (data_byte && state == P_WAIT_D1) data1 <= rx_byte[6:0];
		if (msg_done) begin
			event_key <= data1;
			event_vel <= rx_byte[6:0];
		end
	end

	a_evt_exclusive: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		!(note_on_evt && note_off_evt));

endmodule

/* rtl/voice_alloc.sv */
////////////////////////////////////////////////////////////////////////////
// voice table, maps held keys to voice slots
// keys_on mask and active key count
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module voice_alloc
	import synth_pkg::*;
#(
	parameter int VOICES = VOICES_DEFAULT
) (
	input  logic                   CLOCK_25,
	input  logic                   reset1,
	input  logic                   note_on_evt,
	input  logic                   note_off_evt,
	input  key_t                   event_key,
	input  velocity_t              event_vel,
	output logic [VOICES-1:0]      keys_on,		// one bit per slot
	output logic [$clog2(VOICES):0] active_keys	// 0..VOICES
);

	localparam int IDX_W = (VOICES > 1) ? $clog2(VOICES) : 1;

	key_t      slot_key [VOICES];
	velocity_t slot_vel [VOICES];

	logic [VOICES-1:0] hit;			// slot holds event_key
	logic [VOICES-1:0] vel_zero;
	logic              hit_any;
	logic              free_any;
	logic [IDX_W-1:0]  hit_idx;
	logic [IDX_W-1:0]  free_idx;

	////////////////////////////////////////////////////////////////////////////
	// lookup, lowest index wins
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		hit_any  = 1'b0;
		free_any = 1'b0;
		hit_idx  = '0;
		free_idx = '0;
		// walk down so the lowest slot is the last one written
		for (int i = VOICES - 1; i >= 0; i--) begin
			hit[i]      = keys_on[i] && (slot_key[i] == event_key);
			vel_zero[i] = (slot_vel[i] == '0);
			if (hit[i]) begin
				hit_any = 1'b1;
				hit_idx = IDX_W'(i);
			end
			if (!keys_on[i]) begin
				free_any = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// slot flags and count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			keys_on     <= '0;
			active_keys <= '0;
		end else if (note_on_evt && !hit_any && free_any) begin
			keys_on[free_idx] <= 1'b1;	// new key, table full drops it
			active_keys       <= active_keys + 1'b1;
		end else if (note_off_evt && hit_any) begin
			keys_on[hit_idx] <= 1'b0;	// unknown key off is ignored
			active_keys      <= active_keys - 1'b1;
		end
	end

	// key / velocity store
	always_ff @(posedge CLOCK_25) begin
		if (note_on_evt) begin
			if (hit_any) begin
				slot_vel[hit_idx] <= event_vel;	// retrigger in place
			end else if (free_any) begin
				slot_key[free_idx] <= event_key;
				slot_vel[free_idx] <= event_vel;
			end
		end
	end

	a_count_matches: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		active_keys == $countones(keys_on));

	// parser turns a zero velocity note on into a release, so none is stored
	a_no_silent_voice: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		(keys_on & vel_zero) == '0);

endmodule

/* rtl/synth_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// MIDI input front end, receiver to parser to voice table
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module synth_ctrl_top
	import midi_pkg::*;
	import synth_pkg::*;
#(
	parameter int CLKS_PER_BIT = BAUD_CLKS_DEFAULT,
	parameter int VOICES       = VOICES_DEFAULT
) (
	input  logic                    CLOCK_25,
	input  logic                    reset1,
	input  logic                    midi_rxd,
	input  channel_t                midi_ch,
	output logic [VOICES-1:0]       keys_on,
	output logic [$clog2(VOICES):0] active_keys,
	output pitch_t                  pitch_val
);

	logic       bit_tick;
	logic       sample_start;
	logic       byte_valid;
	midi_byte_t rx_byte;
	logic       note_on_evt;
	logic       note_off_evt;
	key_t       event_key;
	velocity_t  event_vel;

	midi_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_bit_timer (
		.CLOCK_25     (CLOCK_25),
		.reset1       (reset1),
		.sample_start (sample_start),
		.bit_tick     (bit_tick)
	);

	midi_rx u_rx (
		.CLOCK_25     (CLOCK_25),
		.reset1       (reset1),
		.midi_rxd     (midi_rxd),
		.bit_tick     (bit_tick),
		.sample_start (sample_start),
		.byte_valid   (byte_valid),
		.rx_byte      (rx_byte)
	);

	midi_parser u_parser (
		.CLOCK_25     (CLOCK_25),
		.reset1       (reset1),
		.midi_ch      (midi_ch),
		.byte_valid   (byte_valid),
		.rx_byte      (rx_byte),
		.note_on_evt  (note_on_evt),
		.note_off_evt (note_off_evt),
		.event_key    (event_key),
		.event_vel    (event_vel),
		.pitch_val    (pitch_val)		// straight to the engine
	);

	voice_alloc #(.VOICES(VOICES)) u_voice_alloc (
		.CLOCK_25     (CLOCK_25),
		.reset1       (reset1),
		.note_on_evt  (note_on_evt),
		.note_off_evt (note_off_evt),
		.event_key    (event_key),
		.event_vel    (event_vel),
		.keys_on      (keys_on),
		.active_keys  (active_keys)
	);

endmodule

/* verif/tb_model.svh */
////////////////////////////////////////////////////////////////////////////
// reference model of message parsing and voice slots
// serial byte driver for the MIDI input line
////////////////////////////////////////////////////////////////////////////
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int         m_state;	// 0 no status, 1 first data, 2 second data
logic [3:0] m_cmd;
channel_t   m_ch;
data7_t     m_d1;
pitch_t     m_pitch;
key_t       m_key [VOICES];
logic       m_on  [VOICES];

function automatic void model_reset();
	m_state = 0;
	m_cmd   = '0;
	m_ch    = '0;
	m_pitch = PITCH_CENTER;	// wheel at rest
	for (int i = 0; i < VOICES; i++) begin
		m_on[i] = 1'b0;
	end
endfunction

// slot holding key k, -1 if none
function automatic int held_slot(input key_t k);
	for (int i = 0; i < VOICES; i++) begin
		if (m_on[i] && m_key[i] == k) return i;
	end
	return -1;
endfunction

function automatic void voice_on(input key_t k);
	if (held_slot(k) >= 0) return;	// retrigger, same slot
	for (int i = 0; i < VOICES; i++) begin
		if (!m_on[i]) begin
			m_on[i]  = 1'b1;	// lowest free
			m_key[i] = k;
			return;
		end
	end
	// full table, note lost
endfunction

function automatic void voice_off(input key_t k);
	int s;
	s = held_slot(k);
	if (s >= 0) m_on[s] = 1'b0;
endfunction

function automatic void model_byte(input midi_byte_t b);
	logic done;
	done = 1'b0;
	if (b >= 8'hF8) return;	// realtime, invisible
	if (b >= 8'hF0) begin
		m_state = 0;	// sysex / common drops running status
		return;
	end
	if (b[7]) begin
		m_cmd   = b[7:4];
		m_ch    = b[3:0];
		m_state = 1;
		return;
	end
	if (m_state == 1) begin
		if (m_cmd == 4'hC || m_cmd == 4'hD) begin
			done = 1'b1;	// single data byte commands
		end else begin
			m_d1    = b[6:0];
			m_state = 2;
		end
	end else if (m_state == 2) begin
		done    = 1'b1;
		m_state = 1;	// running status
	end
	if (done && m_ch == midi_ch) begin
		if (m_cmd == STATUS_NOTE_ON && b[6:0] != 7'd0) voice_on(m_d1);
		else if (m_cmd == STATUS_NOTE_ON || m_cmd == STATUS_NOTE_OFF) voice_off(m_d1);
		else if (m_cmd == STATUS_PITCH_BEND) m_pitch = {b[6:0], m_d1};	// msb:lsb
	end
endfunction

function automatic mask_t model_mask();
	mask_t m;
	for (int i = 0; i < VOICES; i++) begin
		m[i] = m_on[i];
	end
	return m;
endfunction

function automatic count_t model_count();
	count_t c;
	c = '0;
	for (int i = 0; i < VOICES; i++) begin
		c = c + count_t'(m_on[i]);
	end
	return c;
endfunction

// start, 8 data lsb first, stop, then one idle bit
task automatic send_byte(input midi_byte_t b, input logic stop_bit);
	logic [9:0] frame;
	frame = {stop_bit, b, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge CLOCK_25);
		#1 midi_rxd = frame[i];
		repeat (CLKS_PER_BIT - 1) @(posedge CLOCK_25);
	end
	@(posedge CLOCK_25);
	#1 midi_rxd = 1'b1;
	repeat (CLKS_PER_BIT - 1) @(posedge CLOCK_25);
endtask

`endif

/* verif/synth_ctrl_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the MIDI front end
// random messages checked against a reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module synth_ctrl_tb
	import midi_pkg::*;
	import synth_pkg::*;
();

	localparam int CLKS_PER_BIT = 16;	// short bits
	localparam int VOICES       = 4;
	localparam int SETTLE_CLKS  = 4 * CLKS_PER_BIT;

	typedef logic [VOICES-1:0]       mask_t;
	typedef logic [$clog2(VOICES):0] count_t;

	logic     CLOCK_25;
	logic     reset1;
	logic     midi_rxd;
	channel_t midi_ch;
	mask_t    keys_on;
	count_t   active_keys;
	pitch_t   pitch_val;

	logic [31:0] seed = 32'h0c4d_aa0d;
	int    errors = 0;
	int    checks = 0;
	int    test_no = 0;
	int    test_errs = 0;
	int    tests_failed = 0;
	string test_name;

	`include "tb_model.svh"

	synth_ctrl_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .VOICES(VOICES)) DUT (
		.CLOCK_25    (CLOCK_25),
		.reset1      (reset1),
		.midi_rxd    (midi_rxd),
		.midi_ch     (midi_ch),
		.keys_on     (keys_on),
		.active_keys (active_keys),
		.pitch_val   (pitch_val)
	);

	always #50 CLOCK_25 = ~CLOCK_25;	// 100 ns period

	////////////////////////////////////////////////////////////////////////////
	// random numbers and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// key not in the table yet
	function automatic key_t pick_key();
		key_t k;
		k = key_t'(lcg_next() >> 16);
		while (held_slot(k) >= 0) k = k + 1'b1;
		return k;
	endfunction

	function automatic velocity_t pick_vel();
		return velocity_t'(32'd1 + (lcg_next() >> 8) % 32'd127);	// never 0
	endfunction

	task automatic send(input midi_byte_t b);
		send_byte(b, 1'b1);
		model_byte(b);
	endtask

	task automatic send_note(input logic [3:0] cmd, input key_t k, input velocity_t v);
		send({cmd, midi_ch});
		send({1'b0, k});
		send({1'b0, v});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare and report
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_pitch(input string name, input pitch_t got, input pitch_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_mask(input string name, input mask_t got, input mask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input count_t got, input count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// wait for the outputs to reach the model, bounded
	task automatic settle_and_check();
		logic done;
		done = 1'b0;
		for (int n = 0; n < SETTLE_CLKS && !done; n++) begin
			done = (keys_on === model_mask()) && (active_keys === model_count())
				&& (pitch_val === m_pitch);
			if (!done) begin
				@(posedge CLOCK_25);
				#1;
			end
		end
		if (!done) begin
			errors++;
			$display("timeout: outputs did not settle within %0d clock cycles", SETTLE_CLKS);
		end
		compare_mask("keys_on", keys_on, model_mask());
		compare_count("active_keys", active_keys, model_count());
		compare_pitch("pitch_val", pitch_val, m_pitch);
	endtask

	task automatic start_test(input string name);
		test_no++;
		test_name = name;
		test_errs = errors;
	endtask

	task automatic end_test();
		if (errors == test_errs) begin
			$display("test %0d %s: ok", test_no, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test_no, test_name, errors - test_errs);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		channel_t other;
		data7_t   lsb;
		data7_t   msb;
		CLOCK_25 = 1'b0;
		reset1   = 1'b0;
		midi_rxd = 1'b1;	// line idle
		midi_ch  = channel_t'(lcg_next() >> 12);
		model_reset();
		repeat (2) @(posedge CLOCK_25);
		#1 reset1 = 1'b1;

		start_test("reset values");
		settle_and_check();
		end_test();

		start_test("note-on slot allocation");
		for (int i = 0; i < VOICES - 1; i++) begin
			send_note(STATUS_NOTE_ON, pick_key(), pick_vel());
			settle_and_check();
		end
		// held key again while a slot is still free, stays in its own slot
		send_note(STATUS_NOTE_ON, m_key[int'(lcg_next() % (VOICES - 1))], pick_vel());
		settle_and_check();
		send_note(STATUS_NOTE_ON, pick_key(), pick_vel());	// last free slot
		settle_and_check();
		send_note(STATUS_NOTE_ON, pick_key(), pick_vel());	// no room
		settle_and_check();
		end_test();

		start_test("note release");
		send_note(STATUS_NOTE_OFF, m_key[1], pick_vel());
		settle_and_check();
		send_note(STATUS_NOTE_ON, m_key[0], 7'd0);	// zero velocity
		settle_and_check();
		send_note(STATUS_NOTE_OFF, pick_key(), pick_vel());	// not held
		settle_and_check();
		send_note(STATUS_NOTE_ON, pick_key(), pick_vel());	// back into slot 0
		settle_and_check();
		end_test();

		start_test("running status");
		send({STATUS_NOTE_OFF, midi_ch});	// clear the table, one status
		for (int i = 0; i < VOICES; i++) begin
			if (m_on[i]) begin
				send({1'b0, m_key[i]});
				send(8'h40);
			end
		end
		settle_and_check();
		send({STATUS_NOTE_ON, midi_ch});
		repeat (2) begin
			send({1'b0, pick_key()});
			send({1'b0, pick_vel()});
		end
		settle_and_check();
		send(8'hF6);	// tune request
		send({1'b0, pick_key()});
		send({1'b0, pick_vel()});
		settle_and_check();
		end_test();

		start_test("channel filter and realtime");
		other = midi_ch + 4'd1 + channel_t'(lcg_next() % 15);	// never midi_ch
		send({STATUS_NOTE_ON, other});
		send({1'b0, pick_key()});
		send({1'b0, pick_vel()});
		settle_and_check();
		send({STATUS_NOTE_ON, midi_ch});
		send(8'hF8);	// timing clock
		send({1'b0, pick_key()});
		send(8'hFE);	// active sensing
		send({1'b0, pick_vel()});
		settle_and_check();
		end_test();

		start_test("pitch bend and framing error");
		lsb = data7_t'(lcg_next() >> 9);
		msb = data7_t'(lcg_next() >> 9);
		send({STATUS_PITCH_BEND, midi_ch});
		send({1'b0, lsb});
		send({1'b0, msb});
		settle_and_check();
		send({1'b0, data7_t'(lcg_next() >> 9)});	// next lsb, running status
		send_byte({1'b0, data7_t'(lcg_next() >> 9)}, 1'b0);	// low stop bit, model skips it
		settle_and_check();
		send({1'b0, data7_t'(lcg_next() >> 9)});	// msb completes the bend
		settle_and_check();
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_no, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* midi_synth_ctrl.f */
+incdir+verif
rtl/midi_pkg.sv
rtl/synth_pkg.sv
rtl/midi_bit_timer.sv
rtl/midi_rx.sv
rtl/midi_parser.sv
rtl/voice_alloc.sv
rtl/synth_ctrl_top.sv
verif/synth_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the MIDI front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module synth_ctrl_tb -Mdir obj_dir -f midi_synth_ctrl.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vsynth_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints its verdict, the log decides
if grep -q "Verification passed" "$LOG"; then
	exit 0
fi
echo "no pass line in $LOG"
exit 1
